// ==== Makefile ====
SRCS := $(shell cat vlog.f)

obj_dir/control_unit_tb: vlog.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module control_unit_tb -f vlog.f \
		--Mdir obj_dir -o control_unit_tb

run: obj_dir/control_unit_tb
	obj_dir/control_unit_tb | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== design/control_unit.sv ====
`timescale 1ns/10ps

module control_unit (
        input  logic                 clk,
        input  logic                 reset,
        input  ctrl_pkg::opcode_e    op,
        input  ctrl_pkg::funct_e     funct,
        input  ctrl_pkg::alu_flags_t flags,
        output ctrl_pkg::ctrl_word_t ctrl
);

        ctrl_pkg::decode_t           dec;
        ctrl_pkg::state_e            state;
        logic [ctrl_pkg::STEP_W-1:0] step;
        logic                        last_step;

        instr_decoder u_decoder (
                .op        (op),
                .funct     (funct),
                .dec       (dec)
        );

        step_timer u_timer (
                .clk       (clk),
                .reset     (reset),
                .state     (state),
                .step      (step),
                .last_step (last_step)
        );

        ctrl_fsm u_fsm (
                .clk       (clk),
                .reset     (reset),
                .dec       (dec),
                .flags     (flags),
                .last_step (last_step),
                .state     (state)
        );

        ctrl_encoder u_encoder (
                .state     (state),
                .step      (step),
                .flags     (flags),
                .ctrl      (ctrl)
        );

endmodule

// ==== design/ctrl_encoder.sv ====
`timescale 1ns/10ps

module ctrl_encoder (
        input  ctrl_pkg::state_e              state,
        input  logic [ctrl_pkg::STEP_W-1:0]   step,
        input  ctrl_pkg::alu_flags_t          flags,
        output ctrl_pkg::ctrl_word_t          ctrl
);

        logic last;

        assign last = (step == ctrl_pkg::state_steps(state) - 1'b1);

        always_comb begin
                // Fetch selects give PC + 4 from the PC address
                ctrl           = '0;
                ctrl.pc_src    = ctrl_pkg::pc_alu_result;
                ctrl.alu_src_a = ctrl_pkg::src_a_pc;
                ctrl.alu_src_b = ctrl_pkg::src_b_const_4;
                ctrl.alu_op    = ctrl_pkg::alu_add;
                ctrl.iord      = ctrl_pkg::iord_pc_addr;
                case (state)
                        ctrl_pkg::st_fetch: begin
                                ctrl.ir_write = last;
                                ctrl.pc_write = last;
                        end
                        ctrl_pkg::st_decode: begin
                                // Branch target computed ahead of time
                                ctrl.alu_src_b     = ctrl_pkg::src_b_branch_offset;
                                ctrl.alu_out_write = (step == '0);
                                ctrl.a_write       = (step == '0);
                                ctrl.b_write       = (step == '0);
                        end
                        ctrl_pkg::st_alu_add, ctrl_pkg::st_alu_sub, ctrl_pkg::st_alu_and: begin
                                ctrl.alu_src_a     = ctrl_pkg::src_a_reg_a;
                                ctrl.alu_src_b     = ctrl_pkg::src_b_reg_b;
                                ctrl.alu_op        = (state == ctrl_pkg::st_alu_add) ?
                                                     ctrl_pkg::alu_add :
                                                     (state == ctrl_pkg::st_alu_sub) ?
                                                     ctrl_pkg::alu_sub : ctrl_pkg::alu_and;
                                ctrl.alu_out_write = !last;
                                ctrl.reg_dst       = ctrl_pkg::dst_rd;
                                ctrl.reg_data      = ctrl_pkg::data_alu_out;
                                // Overflow on add/sub drops the result
                                ctrl.bank_write    = last && !(flags.overflow &&
                                                               state != ctrl_pkg::st_alu_and);
                        end
                        ctrl_pkg::st_shift_sll, ctrl_pkg::st_shift_srl,
                        ctrl_pkg::st_shift_sra: begin
                                if (step == '0)
                                        ctrl.sh_op = ctrl_pkg::sh_load;
                                else if (!last)
                                        ctrl.sh_op = (state == ctrl_pkg::st_shift_sll) ?
                                                     ctrl_pkg::sh_left_logical :
                                                     (state == ctrl_pkg::st_shift_srl) ?
                                                     ctrl_pkg::sh_right_logical :
                                                     ctrl_pkg::sh_right_arith;
                                ctrl.reg_dst    = ctrl_pkg::dst_rd;
                                ctrl.reg_data   = ctrl_pkg::data_shifter;
                                ctrl.bank_write = last;
                        end
                        ctrl_pkg::st_mult: begin
                                ctrl.div_mult = last ? ctrl_pkg::dm_idle : ctrl_pkg::dm_mult;
                                ctrl.hi_write = last;
                                ctrl.lo_write = last;
                        end
                        ctrl_pkg::st_div: begin
                                ctrl.div_mult = last ? ctrl_pkg::dm_idle : ctrl_pkg::dm_div;
                                ctrl.hi_write = last && !flags.div_zero;
                                ctrl.lo_write = last && !flags.div_zero;
                        end
                        ctrl_pkg::st_mfhi, ctrl_pkg::st_mflo: begin
                                ctrl.reg_dst    = ctrl_pkg::dst_rd;
                                ctrl.reg_data   = (state == ctrl_pkg::st_mfhi) ?
                                                  ctrl_pkg::data_hi : ctrl_pkg::data_lo;
                                ctrl.bank_write = 1'b1;
                        end
                        ctrl_pkg::st_jr: begin
                                ctrl.alu_src_a = ctrl_pkg::src_a_reg_a;    // Pass rs through
                                ctrl.alu_op    = ctrl_pkg::alu_load;
                                ctrl.pc_write  = 1'b1;
                        end
                        ctrl_pkg::st_beq, ctrl_pkg::st_bne: begin
                                ctrl.alu_src_a = ctrl_pkg::src_a_reg_a;
                                ctrl.alu_src_b = ctrl_pkg::src_b_reg_b;
                                ctrl.alu_op    = ctrl_pkg::alu_cmp;
                        end
                        ctrl_pkg::st_branch_write: begin
                                ctrl.pc_src   = ctrl_pkg::pc_alu_out;
                                ctrl.pc_write = 1'b1;
                        end
                        ctrl_pkg::st_mem_addr: begin
                                ctrl.alu_src_a     = ctrl_pkg::src_a_reg_a;
                                ctrl.alu_src_b     = ctrl_pkg::src_b_mem_offset;
                                ctrl.alu_out_write = (step == '0);
                                if (step != '0)
                                        ctrl.iord = ctrl_pkg::iord_alu_addr;
                                ctrl.mem_reg_write = last;
                        end
                        ctrl_pkg::st_lw: begin
                                ctrl.iord       = ctrl_pkg::iord_alu_addr;
                                ctrl.reg_dst    = ctrl_pkg::dst_rt;
                                ctrl.reg_data   = ctrl_pkg::data_mem_data;
                                ctrl.bank_write = 1'b1;
                        end
                        ctrl_pkg::st_sw: begin
                                ctrl.iord   = ctrl_pkg::iord_alu_addr;
                                ctrl.mem_wr = 1'b1;
                        end
                        ctrl_pkg::st_jal: begin
                                ctrl.reg_dst    = ctrl_pkg::dst_ra;
                                ctrl.reg_data   = ctrl_pkg::data_pc;
                                ctrl.bank_write = 1'b1;
                        end
                        ctrl_pkg::st_j: begin
                                ctrl.pc_src   = ctrl_pkg::pc_jump_target;
                                ctrl.pc_write = 1'b1;
                        end
                        ctrl_pkg::st_exc_opcode, ctrl_pkg::st_exc_overflow,
                        ctrl_pkg::st_exc_divzero: begin
                                // EPC gets PC - 4 and the handler address comes from the vector
                                ctrl.alu_op        = ctrl_pkg::alu_sub;
                                ctrl.pc_src        = ctrl_pkg::pc_exc_load;
                                ctrl.iord          = (state == ctrl_pkg::st_exc_opcode) ?
                                                     ctrl_pkg::iord_exc_opcode :
                                                     (state == ctrl_pkg::st_exc_overflow) ?
                                                     ctrl_pkg::iord_exc_overflow :
                                                     ctrl_pkg::iord_exc_divzero;
                                ctrl.epc_write     = !last;
                                ctrl.mem_reg_write = !last;
                                ctrl.pc_write      = last;
                        end
                        default: begin
                                // brk keeps the fetch selects with all strobes low
                        end
                endcase
        end

endmodule

// ==== design/ctrl_fsm.sv ====
`timescale 1ns/10ps

module ctrl_fsm (
        input  logic                 clk,
        input  logic                 reset,
        input  ctrl_pkg::decode_t    dec,
        input  ctrl_pkg::alu_flags_t flags,
        input  logic                 last_step,
        output ctrl_pkg::state_e     state
);

        ctrl_pkg::state_e state_nxt;

        always_comb begin
                state_nxt = ctrl_pkg::st_fetch;         // Most states return to fetch
                case (state)
                        ctrl_pkg::st_fetch:  state_nxt = ctrl_pkg::st_decode;
                        ctrl_pkg::st_decode: state_nxt = dec.exec_state;
                        ctrl_pkg::st_alu_add,
                        ctrl_pkg::st_alu_sub: begin
                                if (flags.overflow)
                                        state_nxt = ctrl_pkg::st_exc_overflow;
                        end
                        ctrl_pkg::st_div: begin
                                if (flags.div_zero)
                                        state_nxt = ctrl_pkg::st_exc_divzero;
                        end
                        ctrl_pkg::st_beq: begin
                                if (flags.eq)
                                        state_nxt = ctrl_pkg::st_branch_write;
                        end
                        ctrl_pkg::st_bne: begin
                                if (!flags.eq)
                                        state_nxt = ctrl_pkg::st_branch_write;
                        end
                        ctrl_pkg::st_mem_addr: state_nxt = dec.mem_state;
                        ctrl_pkg::st_jal:      state_nxt = ctrl_pkg::st_j;     // Link, then jump
                        ctrl_pkg::st_brk:      state_nxt = ctrl_pkg::st_brk;
                        default:               state_nxt = ctrl_pkg::st_fetch;
                endcase
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        state <= ctrl_pkg::st_fetch;
                end else if (last_step) begin
                        state <= state_nxt;
                end
        end

endmodule

// ==== design/ctrl_pkg.sv ====
package ctrl_pkg;

        localparam int STEP_W = 6;

        // State durations in clock cycles
        localparam logic [STEP_W-1:0] FETCH_STEPS    = 6'd4;
        localparam logic [STEP_W-1:0] DECODE_STEPS   = 6'd2;
        localparam logic [STEP_W-1:0] ALU_STEPS      = 6'd2;
        localparam logic [STEP_W-1:0] SHIFT_STEPS    = 6'd3;
        localparam logic [STEP_W-1:0] MULT_STEPS     = 6'd33;
        localparam logic [STEP_W-1:0] DIV_STEPS      = 6'd34;
        localparam logic [STEP_W-1:0] MEM_ADDR_STEPS = 6'd4;
        localparam logic [STEP_W-1:0] EXC_STEPS      = 6'd4;

        typedef enum logic [5:0] {
                op_rtype = 6'h00, op_j  = 6'h02, op_jal = 6'h03, op_beq = 6'h04,
                op_bne   = 6'h05, op_lw = 6'h23, op_sw  = 6'h2b
        } opcode_e;

        typedef enum logic [5:0] {
                fn_sll  = 6'h00, fn_srl  = 6'h02, fn_sra  = 6'h03, fn_jr   = 6'h08,
                fn_brk  = 6'h0d, fn_mfhi = 6'h10, fn_mflo = 6'h12, fn_mult = 6'h18,
                fn_div  = 6'h1a, fn_add  = 6'h20, fn_sub  = 6'h22, fn_and  = 6'h24
        } funct_e;

        typedef enum logic [4:0] {
                st_fetch, st_decode, st_alu_add, st_alu_sub, st_alu_and,
                st_shift_sll, st_shift_srl, st_shift_sra, st_mult, st_div,
                st_mfhi, st_mflo, st_jr, st_beq, st_bne, st_branch_write,
                st_mem_addr, st_lw, st_sw, st_j, st_jal,
                st_exc_opcode, st_exc_overflow, st_exc_divzero, st_brk
        } state_e;

        typedef enum logic [2:0] {
                alu_load = 3'd0, alu_add = 3'd1, alu_sub = 3'd2, alu_and = 3'd3, alu_cmp = 3'd7
        } alu_op_e;

        typedef enum logic [1:0] {
                pc_alu_result, pc_alu_out, pc_jump_target, pc_exc_load
        } pc_src_e;

        typedef enum logic [1:0] {src_a_pc, src_a_reg_a, src_a_reg_b} alu_src_a_e;

        typedef enum logic [1:0] {
                src_b_reg_b, src_b_const_4, src_b_branch_offset, src_b_mem_offset
        } alu_src_b_e;

        typedef enum logic [2:0] {
                sh_idle, sh_load, sh_left_logical, sh_right_logical, sh_right_arith
        } sh_op_e;

        typedef enum logic [1:0] {dm_idle, dm_mult, dm_div} div_mult_e;

        // Exception vectors sit after the two normal address sources
        typedef enum logic [2:0] {
                iord_pc_addr, iord_alu_addr, iord_exc_opcode, iord_exc_overflow, iord_exc_divzero
        } iord_e;

        typedef enum logic [2:0] {dst_rt = 3'd0, dst_rd = 3'd1, dst_ra = 3'd4} reg_dst_e;

        typedef enum logic [2:0] {
                data_alu_out = 3'd0, data_mem_data = 3'd1, data_shifter = 3'd2,
                data_hi = 3'd3, data_lo = 3'd4, data_pc = 3'd6
        } reg_data_e;

        typedef struct packed {
                logic overflow;
                logic div_zero;
                logic eq;
        } alu_flags_t;

        typedef struct packed {
                pc_src_e    pc_src;
                alu_src_a_e alu_src_a;
                alu_src_b_e alu_src_b;
                alu_op_e    alu_op;
                sh_op_e     sh_op;
                div_mult_e  div_mult;
                iord_e      iord;
                reg_dst_e   reg_dst;
                reg_data_e  reg_data;
                logic       mem_wr;
                logic       ir_write;
                logic       pc_write;
                logic       bank_write;
                logic       epc_write;
                logic       a_write;
                logic       b_write;
                logic       alu_out_write;
                logic       lo_write;
                logic       hi_write;
                logic       mem_reg_write;
        } ctrl_word_t;

        typedef struct packed {
                state_e exec_state;
                state_e mem_state;
        } decode_t;

        function automatic logic [STEP_W-1:0] state_steps(state_e s);
                case (s)
                        st_fetch:                               return FETCH_STEPS;
                        st_decode:                              return DECODE_STEPS;
                        st_alu_add, st_alu_sub, st_alu_and:     return ALU_STEPS;
                        st_shift_sll, st_shift_srl, st_shift_sra: return SHIFT_STEPS;
                        st_mult:                                return MULT_STEPS;
                        st_div:                                 return DIV_STEPS;
                        st_mem_addr:                            return MEM_ADDR_STEPS;
                        st_exc_opcode, st_exc_overflow, st_exc_divzero: return EXC_STEPS;
                        default:                                return 6'd1;
                endcase
        endfunction

endpackage

// ==== design/instr_decoder.sv ====
`timescale 1ns/10ps

module instr_decoder (
        input  ctrl_pkg::opcode_e op,
        input  ctrl_pkg::funct_e  funct,
        output ctrl_pkg::decode_t dec
);

        always_comb begin
                dec.exec_state = ctrl_pkg::st_exc_opcode;
                case (op)
                        ctrl_pkg::op_rtype: begin
                                case (funct)
                                        ctrl_pkg::fn_add:  dec.exec_state = ctrl_pkg::st_alu_add;
                                        ctrl_pkg::fn_sub:  dec.exec_state = ctrl_pkg::st_alu_sub;
                                        ctrl_pkg::fn_and:  dec.exec_state = ctrl_pkg::st_alu_and;
                                        ctrl_pkg::fn_sll:  dec.exec_state = ctrl_pkg::st_shift_sll;
                                        ctrl_pkg::fn_srl:  dec.exec_state = ctrl_pkg::st_shift_srl;
                                        ctrl_pkg::fn_sra:  dec.exec_state = ctrl_pkg::st_shift_sra;
                                        ctrl_pkg::fn_mult: dec.exec_state = ctrl_pkg::st_mult;
                                        ctrl_pkg::fn_div:  dec.exec_state = ctrl_pkg::st_div;
                                        ctrl_pkg::fn_mfhi: dec.exec_state = ctrl_pkg::st_mfhi;
                                        ctrl_pkg::fn_mflo: dec.exec_state = ctrl_pkg::st_mflo;
                                        ctrl_pkg::fn_jr:   dec.exec_state = ctrl_pkg::st_jr;
                                        ctrl_pkg::fn_brk:  dec.exec_state = ctrl_pkg::st_brk;
                                        default:           dec.exec_state = ctrl_pkg::st_exc_opcode;
                                endcase
                        end
                        ctrl_pkg::op_beq: dec.exec_state = ctrl_pkg::st_beq;
                        ctrl_pkg::op_bne: dec.exec_state = ctrl_pkg::st_bne;
                        ctrl_pkg::op_lw,
                        ctrl_pkg::op_sw:  dec.exec_state = ctrl_pkg::st_mem_addr;
                        ctrl_pkg::op_j:   dec.exec_state = ctrl_pkg::st_j;
                        ctrl_pkg::op_jal: dec.exec_state = ctrl_pkg::st_jal;
                        default:          dec.exec_state = ctrl_pkg::st_exc_opcode;
                endcase
        end

        // Only read after mem_addr, so lw is a safe fallback
        assign dec.mem_state = (op == ctrl_pkg::op_sw) ? ctrl_pkg::st_sw : ctrl_pkg::st_lw;

endmodule

// ==== design/step_timer.sv ====
`timescale 1ns/10ps

module step_timer (
        input  logic                          clk,
        input  logic                          reset,
        input  ctrl_pkg::state_e              state,
        output logic [ctrl_pkg::STEP_W-1:0]   step,
        output logic                          last_step
);

        logic [ctrl_pkg::STEP_W-1:0] dur;

        assign dur = ctrl_pkg::state_steps(state);

        // brk parks the counter at 0 with last_step held
        assign last_step = (state == ctrl_pkg::st_brk) || (step == dur - 1'b1);

        always_ff @(posedge clk) begin
                if (reset) begin
                        step <= '0;
                end else if (last_step) begin
                        step <= '0;             // Wrap with the state change
                end else begin
                        step <= step + 1'b1;
                end
        end

endmodule

// ==== dv/control_unit_tb.sv ====
`timescale 1ns/10ps

module control_unit_tb;

        localparam int NUM_INSTR      = 200;
        localparam int NUM_KINDS      = 19;
        localparam int CLK_HALF       = 20;
        localparam int TIMEOUT_CYCLES = NUM_INSTR * 40 + 2000;
        localparam int HALT_WAIT      = 100;
        localparam int SEED           = 18037;

        logic                 clk;
        logic                 reset;
        ctrl_pkg::opcode_e    op;
        ctrl_pkg::funct_e     funct;
        ctrl_pkg::alu_flags_t flags;
        ctrl_pkg::ctrl_word_t ctrl;

        // Expected behavior of the instruction in flight
        int                   exp_len = 0;
        int                   exp_bank = 0;
        ctrl_pkg::reg_data_e  exp_data = ctrl_pkg::data_alu_out;
        int                   exp_mem_wr = 0;
        int                   exp_hilo = 0;
        int                   exp_epc = 0;
        int                   exp_exc_pc = 0;
        int                   exp_branch = 0;
        ctrl_pkg::iord_e      exp_vec = ctrl_pkg::iord_pc_addr;
        logic                 halted = 1'b0;

        int                   cyc_after_reset = 0;
        int                   since_fetch = 0;
        int                   bank_cnt = 0;
        int                   mem_wr_cnt = 0;
        int                   hilo_cnt = 0;
        int                   epc_cnt = 0;
        int                   exc_pc_cnt = 0;
        int                   branch_cnt = 0;
        logic                 seen_first = 1'b0;

        control_unit u_dut (
                .clk   (clk),
                .reset (reset),
                .op    (op),
                .funct (funct),
                .flags (flags),
                .ctrl  (ctrl)
        );

        initial begin
                clk = 1'b0;
                forever #(CLK_HALF) clk = ~clk;
        end

        initial begin
                #(TIMEOUT_CYCLES * 2 * CLK_HALF);
                $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
                $display("CHECKS FAILED");
                $fatal(1);
        end

        task automatic fail_value(input string name, input int got, input int exp);
                $display("FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp);
                $display("CHECKS FAILED");
                $fatal(1);
        endtask

        task automatic fail_text(input string what);
                $display("%s (at %0t)", what, $time);
                $display("CHECKS FAILED");
                $fatal(1);
        endtask

        fetch_selects: assert property (@(posedge clk) disable iff (reset)
                ctrl.ir_write |-> ctrl.pc_write && ctrl.pc_src == ctrl_pkg::pc_alu_result &&
                                  ctrl.iord == ctrl_pkg::iord_pc_addr)
                else fail_text("ir_write without pc_write, pc_src alu_result and iord pc_addr");

        hilo_together: assert property (@(posedge clk) disable iff (reset)
                ctrl.hi_write == ctrl.lo_write)
                else fail_text("hi_write and lo_write are not raised together");

        exc_pc_after_epc: assert property (@(posedge clk) disable iff (reset)
                ctrl.pc_write && ctrl.pc_src == ctrl_pkg::pc_exc_load |-> $past(ctrl.epc_write))
                else fail_text("exception pc_write not preceded by epc_write");

        task automatic clear_counts();
                since_fetch = 0;
                bank_cnt    = 0;
                mem_wr_cnt  = 0;
                hilo_cnt    = 0;
                epc_cnt     = 0;
                exc_pc_cnt  = 0;
                branch_cnt  = 0;
        endtask

        task automatic check_counts();
                assert (since_fetch == exp_len)
                else fail_value("instruction cycles", since_fetch, exp_len);
                assert (bank_cnt == exp_bank)
                else fail_value("bank_write count", bank_cnt, exp_bank);
                assert (mem_wr_cnt == exp_mem_wr)
                else fail_value("mem_wr count", mem_wr_cnt, exp_mem_wr);
                assert (hilo_cnt == exp_hilo)
                else fail_value("hi_write count", hilo_cnt, exp_hilo);
                assert (epc_cnt == exp_epc)
                else fail_value("epc_write count", epc_cnt, exp_epc);
                assert (exc_pc_cnt == exp_exc_pc)
                else fail_value("exception pc_write count", exc_pc_cnt, exp_exc_pc);
                assert (branch_cnt == exp_branch)
                else fail_value("branch pc_write count", branch_cnt, exp_branch);
        endtask

        // Mid-cycle monitor counting strobes between ir_write pulses
        always @(negedge clk) begin
                if (!reset) begin
                        cyc_after_reset++;
                        since_fetch++;
                        if (ctrl.bank_write) begin
                                bank_cnt++;
                                assert (ctrl.reg_data == exp_data)
                                else fail_value("reg_data", int'(ctrl.reg_data), int'(exp_data));
                        end
                        if (ctrl.mem_wr)
                                mem_wr_cnt++;
                        if (ctrl.hi_write) begin
                                hilo_cnt++;
                                assert (since_fetch == exp_len - 4)   // Last cycle of the instruction
                                else fail_value("hi_write cycle", since_fetch + 4, exp_len);
                        end
                        if (ctrl.epc_write) begin
                                epc_cnt++;
                                assert (ctrl.iord == exp_vec)
                                else fail_value("iord", int'(ctrl.iord), int'(exp_vec));
                        end
                        if (ctrl.pc_write && ctrl.pc_src == ctrl_pkg::pc_exc_load)
                                exc_pc_cnt++;
                        if (ctrl.pc_write && ctrl.pc_src == ctrl_pkg::pc_alu_out)
                                branch_cnt++;
                        if (ctrl.ir_write) begin
                                assert (!halted)
                                else fail_text("ir_write rose again after break");
                                if (!seen_first) begin
                                        assert (cyc_after_reset == 4)
                                        else fail_value("first ir_write cycle",
                                                        cyc_after_reset, 4);
                                end else begin
                                        check_counts();
                                end
                                seen_first = 1'b1;
                                clear_counts();
                        end
                end
        end

        task automatic take_exception(input int base, input ctrl_pkg::iord_e vec);
                exp_len    = base + 4;
                exp_epc    = 3;
                exp_exc_pc = 1;
                exp_vec    = vec;
        endtask

        // Sets the inputs and the expected behavior of one instruction
        task automatic issue_instr(input int kind);
                logic [31:0] rnd;
                rnd            = $urandom;
                flags.overflow = rnd[0];
                flags.div_zero = rnd[1];
                flags.eq       = rnd[2];
                op             = ctrl_pkg::op_rtype;
                exp_len        = 7;
                exp_bank       = 0;
                exp_data       = ctrl_pkg::data_alu_out;
                exp_mem_wr     = 0;
                exp_hilo       = 0;
                exp_epc        = 0;
                exp_exc_pc     = 0;
                exp_branch     = 0;
                exp_vec        = ctrl_pkg::iord_pc_addr;
                case (kind)
                        0, 1: begin
                                funct = (kind == 0) ? ctrl_pkg::fn_add : ctrl_pkg::fn_sub;
                                if (flags.overflow) begin
                                        take_exception(8, ctrl_pkg::iord_exc_overflow);
                                end else begin
                                        exp_len  = 8;
                                        exp_bank = 1;
                                end
                        end
                        2: begin
                                funct    = ctrl_pkg::fn_and;   // Overflow ignored
                                exp_len  = 8;
                                exp_bank = 1;
                        end
                        3, 4, 5: begin
                                funct    = (kind == 3) ? ctrl_pkg::fn_sll :
                                           (kind == 4) ? ctrl_pkg::fn_srl : ctrl_pkg::fn_sra;
                                exp_len  = 9;
                                exp_bank = 1;
                                exp_data = ctrl_pkg::data_shifter;
                        end
                        6: begin
                                funct    = ctrl_pkg::fn_mult;
                                exp_len  = 39;
                                exp_hilo = 1;
                        end
                        7: begin
                                funct = ctrl_pkg::fn_div;
                                if (flags.div_zero) begin
                                        take_exception(40, ctrl_pkg::iord_exc_divzero);
                                end else begin
                                        exp_len  = 40;
                                        exp_hilo = 1;
                                end
                        end
                        8, 9: begin
                                funct    = (kind == 8) ? ctrl_pkg::fn_mfhi : ctrl_pkg::fn_mflo;
                                exp_bank = 1;
                                exp_data = (kind == 8) ? ctrl_pkg::data_hi : ctrl_pkg::data_lo;
                        end
                        10: funct = ctrl_pkg::fn_jr;
                        11, 12: begin
                                op = (kind == 11) ? ctrl_pkg::op_beq : ctrl_pkg::op_bne;
                                if (flags.eq == (kind == 11)) begin
                                        exp_len    = 8;
                                        exp_branch = 1;
                                end
                        end
                        13: begin
                                op       = ctrl_pkg::op_lw;
                                exp_len  = 11;
                                exp_bank = 1;
                                exp_data = ctrl_pkg::data_mem_data;
                        end
                        14: begin
                                op         = ctrl_pkg::op_sw;
                                exp_len    = 11;
                                exp_mem_wr = 1;
                        end
                        15: op = ctrl_pkg::op_j;
                        16: begin
                                op       = ctrl_pkg::op_jal;
                                exp_len  = 8;
                                exp_bank = 1;
                                exp_data = ctrl_pkg::data_pc;
                        end
                        17: begin
                                op = ctrl_pkg::opcode_e'(6'h3f);
                                take_exception(6, ctrl_pkg::iord_exc_opcode);
                        end
                        default: begin
                                funct = ctrl_pkg::funct_e'(6'h3f);   // Unknown function code
                                take_exception(6, ctrl_pkg::iord_exc_opcode);
                        end
                endcase
        endtask

        task automatic wait_fetch();
                do
                        @(negedge clk);
                while (!ctrl.ir_write);
                @(posedge clk);
                #2;
        endtask

        initial begin
                int n;
                void'($urandom(SEED));
                reset = 1'b1;
                op    = ctrl_pkg::op_rtype;
                funct = ctrl_pkg::fn_add;
                flags = '0;
                repeat (5) @(posedge clk);
                #2;
                reset = 1'b0;
                for (n = 0; n < NUM_INSTR; n++) begin
                        wait_fetch();
                        issue_instr($urandom_range(NUM_KINDS - 1, 0));
                end
                wait_fetch();
                op     = ctrl_pkg::op_rtype;
                funct  = ctrl_pkg::fn_brk;
                flags  = '0;
                halted = 1'b1;
                repeat (HALT_WAIT) @(negedge clk);
                $display("ALL CHECKS PASSED");
                $finish;
        end

endmodule

// ==== vlog.f ====
design/ctrl_pkg.sv
design/instr_decoder.sv
design/step_timer.sv
design/ctrl_fsm.sv
design/ctrl_encoder.sv
design/control_unit.sv
dv/control_unit_tb.sv
